/* verilog.f */
+incdir+bench
hw/anticPkg.sv
hw/lineCtrlIf.sv
hw/charPixelGen.sv
hw/mapPixelGen.sv
hw/modeLineEngine.sv
hw/dlistSequencer.sv
hw/displayListTranslator.sv
bench/tbDisplayList.sv

/* bench/dlistModel.svh */
/* Display-list reference model
   Predicts the ordered strobe and pixel events of a display list and its worst-case length */

// Strobes in the order the monitor reports them within one cycle
typedef enum int {
  EvWriteNmi = 1,
  EvLoadDlistL,
  EvLoadDlistH,
  EvWriteDlist,
  EvLoadDlist,
  EvDlistEnd,
  EvLoadMsrL,
  EvLoadMsrH,
  EvLoadIr,
  EvLoadMsrData,
  EvLoadChar
} strobeId_t;

// Pixel events hold the 4-bit code while strobe events sit at multiples of 16
task automatic pushStrobe(input strobeId_t id);
  expected.push_back(16 * id);
endtask

function automatic int bytesForWidth(input anticPkg::pfWidth_t width);
  case (width)
    2'd1:    return anticPkg::NarrowBytes;
    2'd2:    return anticPkg::StandardBytes;
    2'd3:    return anticPkg::WideBytes;
    default: return 0;
  endcase
endfunction

function automatic anticPkg::anCode_t mapCode(input logic [1:0] pair);
  case (pair)
    2'd0:    return anticPkg::AnBg;
    2'd1:    return anticPkg::AnPf0;
    2'd2:    return anticPkg::AnPf1;
    default: return anticPkg::AnPf2;
  endcase
endfunction

task automatic buildExpected();
  int p;
  int lineBytes;
  int reps;
  anticPkg::byte_t instr;
  anticPkg::byte_t data;
  p = 0;
  screenUsed = 0;
  bitmapsUsed = 0;
  worstCycles = 0;
  pushStrobe(EvLoadIr);
  while (p < listLen) begin
    instr = listMem[p];
    lineBytes = bytesForWidth(widthMem[p]);
    p++;
    worstCycles += 8;
    if (instr[7]) pushStrobe(EvWriteNmi);
    case (instr[3:0])
      anticPkg::ModeJump: begin
        pushStrobe(EvLoadIr);
        pushStrobe(EvLoadDlistL);
        pushStrobe(EvLoadIr);
        pushStrobe(EvLoadDlistH);
        pushStrobe(EvWriteDlist);
        pushStrobe(EvLoadDlist);
        if (instr[6]) begin
          pushStrobe(EvDlistEnd);
          worstCycles += anticPkg::VblankWaitCycles;
        end
        p += 2;
        worstCycles += 15;
      end
      anticPkg::ModeChar, anticPkg::ModeMapDouble, anticPkg::ModeMapSingle: begin
        if (instr[6]) begin
          pushStrobe(EvLoadIr);
          pushStrobe(EvLoadMsrL);
          pushStrobe(EvLoadIr);
          pushStrobe(EvLoadMsrH);
          p += 2;
          worstCycles += 14;
        end
        reps = (instr[3:0] == anticPkg::ModeMapDouble) ? 2 : 1;
        worstCycles += 4;
        for (int n = 0; n < lineBytes; n++) begin
          pushStrobe(EvLoadMsrData);
          data = screenMem[screenUsed];
          screenUsed++;
          if (instr[3:0] == anticPkg::ModeChar) begin
            pushStrobe(EvLoadChar);
            for (int i = 0; i < anticPkg::CharBits; i++) begin
              expected.push_back(bitmapMem[bitmapsUsed][i] ? anticPkg::AnPf1 : anticPkg::AnPf2);
            end
            bitmapsUsed++;
            worstCycles += 84;
          end else begin
            // High bit pair first
            for (int k = 0; k < 4; k++) begin
              for (int r = 0; r < reps; r++) expected.push_back(mapCode(data[7-2*k -: 2]));
            end
            worstCycles += 14 + 4 * reps;
          end
        end
      end
      default: begin
        // Blank goes straight to the next instruction fetch
      end
    endcase
    pushStrobe(EvLoadIr);
  end
endtask

/* bench/tbDisplayList.sv */
/* Display-list translator testbench
   Random display lists served to the DUT, strobes and pixel codes checked against a model */
`timescale 1ns/1ps

module tbDisplayList;

  logic Fphi0;
  logic rst;
  anticPkg::byte_t ir;
  logic irRdy;
  anticPkg::pfWidth_t playfieldWidth;
  anticPkg::byte_t msrData;
  logic msrDataRdy;
  anticPkg::charBitmap_t charData;
  logic charLoaded;
  anticPkg::anCode_t an;
  logic loadIr, loadDlistL, loadDlistH, loadPtr, writeDlist, loadDlist, dlistEnd;
  logic loadMsrL, loadMsrH, loadMsrData, incrMsr, loadChar, writeNmi, writeDli, clearDli;

  // Display list bytes with the playfield width that goes with each
  anticPkg::byte_t listMem [128];
  anticPkg::pfWidth_t widthMem [128];
  anticPkg::byte_t screenMem [2048];
  anticPkg::charBitmap_t bitmapMem [2048];
  int listLen, screenUsed, bitmapsUsed, worstCycles;
  int listPtr, screenPtr, bitmapPtr;
  int irDelay, msrDelay, charDelay;
  int expected [$];
  logic [31:0] rngState;
  longint watchdogNs;
  logic [10:0] strobeVec;
  logic prevNmi, prevDli, ptrOpen, vblankOpen, prevPixel;
  int vblankCycles;

  `include "dlistModel.svh"

  displayListTranslator u_displayListTranslator (.*);

  always #50 Fphi0 = ~Fphi0;

  function automatic logic [31:0] nextRandom();
    rngState ^= rngState << 13;
    rngState ^= rngState >> 17;
    rngState ^= rngState << 5;
    return rngState;
  endfunction

  function automatic int pickLatency();
    return 1 + (nextRandom() % 4);
  endfunction

  function automatic string strobeName(input int id);
    case (id)
      1:       return "writeNmi";
      2:       return "loadDlistL";
      3:       return "loadDlistH";
      4:       return "writeDlist";
      5:       return "loadDlist";
      6:       return "dlistEnd";
      7:       return "loadMsrL";
      8:       return "loadMsrH";
      9:       return "loadIr";
      10:      return "loadMsrData";
      default: return "loadChar";
    endcase
  endfunction

  function automatic string describe(input int ev);
    if (ev < 16) return $sformatf("code %0h", ev);
    return strobeName(ev / 16);
  endfunction

  task automatic stopOnError();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic reportMismatch(input string sig, input string want, input string got);
    $display("Fail at %0d ns: %s expected %s, got %s", $time, sig, want, got);
    stopOnError();
  endtask

  task automatic buildList();
    logic [31:0] r;
    anticPkg::mode_t mode;
    anticPkg::pfWidth_t width;
    int charLines;
    charLines = 0;
    listLen = 0;
    for (int i = 0; i < 40; i++) begin
      r = nextRandom();
      case (r % 5)
        0:       mode = anticPkg::ModeBlank;
        1:       mode = anticPkg::ModeJump;
        2:       mode = anticPkg::ModeChar;
        3:       mode = anticPkg::ModeMapDouble;
        default: mode = anticPkg::ModeMapSingle;
      endcase
      width = r[17:16];
      // Text lines cycle through every width
      if (mode == anticPkg::ModeChar) begin
        width = anticPkg::pfWidth_t'(charLines % 4);
        charLines++;
      end
      listMem[listLen] = {r[31], r[30], 2'b00, mode};
      widthMem[listLen] = width;
      listLen++;
      if (mode == anticPkg::ModeJump || (r[30] && mode != anticPkg::ModeBlank)) begin
        for (int j = 0; j < 2; j++) begin
          listMem[listLen] = anticPkg::byte_t'(nextRandom());
          widthMem[listLen] = width;
          listLen++;
        end
      end
    end
    for (int i = 0; i < 2048; i++) begin
      screenMem[i] = anticPkg::byte_t'(nextRandom());
      bitmapMem[i] = {nextRandom(), nextRandom()};
    end
  endtask

  task automatic observe(input int ev, input string sig);
    int want;
    assert (expected.size() != 0) else begin
      $display("Unexpected %s at %0d ns after all predicted events", describe(ev), $time);
      stopOnError();
    end
    want = expected.pop_front();
    assert (want == ev) else reportMismatch(sig, describe(want), describe(ev));
  endtask

  // The memory responder answers each request after a random latency
  always @(negedge Fphi0) begin
    irRdy = 1'b0;
    msrDataRdy = 1'b0;
    charLoaded = 1'b0;
    if (!rst) begin
      if (irDelay == 1) begin
        ir = listMem[listPtr];
        playfieldWidth = widthMem[listPtr];
        listPtr++;
        irRdy = 1'b1;
      end
      if (msrDelay == 1) begin
        msrData = screenMem[screenPtr];
        screenPtr++;
        msrDataRdy = 1'b1;
      end
      if (charDelay == 1) begin
        charData = bitmapMem[bitmapPtr];
        bitmapPtr++;
        charLoaded = 1'b1;
      end
      if (irDelay > 0) irDelay--;
      if (msrDelay > 0) msrDelay--;
      if (charDelay > 0) charDelay--;
      if (loadIr && listPtr < listLen) irDelay = pickLatency();
      if (loadMsrData) msrDelay = pickLatency();
      if (loadChar) charDelay = pickLatency();
    end
  end

  assign strobeVec = {loadChar, loadMsrData, loadIr, loadMsrH, loadMsrL, dlistEnd, loadDlist,
                      writeDlist, loadDlistH, loadDlistL, writeNmi};

  always @(negedge Fphi0) begin
    if (rst) begin
      assert (an == anticPkg::AnIdle && strobeVec == '0 && !loadPtr && !incrMsr &&
              !writeDli && !clearDli) else begin
        $display("Outputs are active while reset is held at %0d ns", $time);
        stopOnError();
      end
    end else begin
      // Pixels of one byte leave on consecutive cycles
      if (prevPixel && expected.size() != 0 && expected[0] < 16) begin
        assert (an != anticPkg::AnIdle) else begin
          $display("Gap in the pixel stream of a byte at %0d ns", $time);
          stopOnError();
        end
      end
      for (int i = 0; i < 11; i++) begin
        if (strobeVec[i]) observe(16 * (i + 1), strobeName(i + 1));
      end
      if (an != anticPkg::AnIdle) observe(an, "an");
      assert (incrMsr == loadMsrData) else
        reportMismatch("incrMsr", $sformatf("%0b", loadMsrData), $sformatf("%0b", incrMsr));
      assert (writeDli == prevNmi) else
        reportMismatch("writeDli", $sformatf("%0b", prevNmi), $sformatf("%0b", writeDli));
      assert (clearDli == prevDli) else
        reportMismatch("clearDli", $sformatf("%0b", prevDli), $sformatf("%0b", clearDli));
      assert (loadPtr == ((loadDlistL || ptrOpen) && !loadDlist)) else
        reportMismatch("loadPtr", $sformatf("%0b", !loadPtr), $sformatf("%0b", loadPtr));
      // The wait adds VblankWaitCycles to the single JumpEnd cycle
      if (vblankOpen) vblankCycles++;
      if (loadIr && vblankOpen) begin
        assert (vblankCycles == anticPkg::VblankWaitCycles + 1) else
          reportMismatch("loadIr", $sformatf("%0d cycles after loadDlist",
                         anticPkg::VblankWaitCycles + 1), $sformatf("%0d", vblankCycles));
        vblankOpen = 1'b0;
      end
      if (loadDlist && dlistEnd) begin
        vblankOpen = 1'b1;
        vblankCycles = 0;
      end
      prevNmi = writeNmi;
      prevDli = writeDli;
      prevPixel = (an != anticPkg::AnIdle);
      ptrOpen = (loadDlistL || ptrOpen) && !loadDlist;
    end
  end

  initial begin
    #1;
    #(watchdogNs);
    $display("Watchdog expired after %0d ns with %0d events still pending",
             watchdogNs, expected.size());
    stopOnError();
  end

  initial begin
    Fphi0 = 1'b0;
    rst = 1'b1;
    ir = '0;
    irRdy = 1'b0;
    playfieldWidth = '0;
    msrData = '0;
    msrDataRdy = 1'b0;
    charData = '0;
    charLoaded = 1'b0;
    {listPtr, screenPtr, bitmapPtr, irDelay, msrDelay, charDelay} = '0;
    {prevNmi, prevDli, ptrOpen, vblankOpen, prevPixel} = '0;
    vblankCycles = 0;
    rngState = 32'd32183;
    buildList();
    buildExpected();
    watchdogNs = (longint'(worstCycles) * 11 / 10 + 40) * 100;
    repeat (10) @(negedge Fphi0);
    rst = 1'b0;
    while (expected.size() != 0) @(negedge Fphi0);
    repeat (20) @(negedge Fphi0);
    if (listPtr != listLen || screenPtr != screenUsed || bitmapPtr != bitmapsUsed) begin
      $display("The DUT did not fetch the whole display list and its screen data");
      stopOnError();
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

/* hw/displayListTranslator.sv */
/* Display-list translator
   Fetches and decodes display-list instructions and streams 4-bit pixel codes to the colour chip */
`timescale 1ns/1ps

module displayListTranslator (
  input  logic                   Fphi0,
  input  logic                   rst,
  input  anticPkg::byte_t        ir,
  input  logic                   irRdy,
  input  anticPkg::pfWidth_t     playfieldWidth,
  input  anticPkg::byte_t        msrData,
  input  logic                   msrDataRdy,
  input  anticPkg::charBitmap_t  charData,
  input  logic                   charLoaded,
  output anticPkg::anCode_t      an,
  output logic                   loadIr,
  output logic                   loadDlistL,
  output logic                   loadDlistH,
  output logic                   loadPtr,
  output logic                   writeDlist,
  output logic                   loadDlist,
  output logic                   dlistEnd,
  output logic                   loadMsrL,
  output logic                   loadMsrH,
  output logic                   loadMsrData,
  output logic                   incrMsr,
  output logic                   loadChar,
  output logic                   writeNmi,
  output logic                   writeDli,
  output logic                   clearDli
);

  lineCtrlIf lineBus ();

  dlistSequencer uDlistSequencer (
    .Fphi0          (Fphi0),
    .rst            (rst),
    .ir             (ir),
    .irRdy          (irRdy),
    .playfieldWidth (playfieldWidth),
    .loadIr         (loadIr),
    .loadDlistL     (loadDlistL),
    .loadDlistH     (loadDlistH),
    .loadPtr        (loadPtr),
    .writeDlist     (writeDlist),
    .loadDlist      (loadDlist),
    .dlistEnd       (dlistEnd),
    .loadMsrL       (loadMsrL),
    .loadMsrH       (loadMsrH),
    .writeNmi       (writeNmi),
    .writeDli       (writeDli),
    .clearDli       (clearDli),
    .line           (lineBus.seq)
  );

  modeLineEngine uModeLineEngine (
    .Fphi0       (Fphi0),
    .rst         (rst),
    .msrData     (msrData),
    .msrDataRdy  (msrDataRdy),
    .charData    (charData),
    .charLoaded  (charLoaded),
    .an          (an),
    .loadMsrData (loadMsrData),
    .incrMsr     (incrMsr),
    .loadChar    (loadChar),
    .line        (lineBus.eng)
  );

endmodule

/* hw/dlistSequencer.sv */
/* Display-list sequencer
   Fetches and decodes instructions, runs jumps, LMS loads, vblank waits and DLI strobes */
`timescale 1ns/1ps

module dlistSequencer (
  input  logic               Fphi0,
  input  logic               rst,
  input  anticPkg::byte_t    ir,
  input  logic               irRdy,
  input  anticPkg::pfWidth_t playfieldWidth,
  output logic               loadIr,
  output logic               loadDlistL,
  output logic               loadDlistH,
  output logic               loadPtr,
  output logic               writeDlist,
  output logic               loadDlist,
  output logic               dlistEnd,
  output logic               loadMsrL,
  output logic               loadMsrH,
  output logic               writeNmi,
  output logic               writeDli,
  output logic               clearDli,
  lineCtrlIf.seq             line
);

  anticPkg::seqState_t state;
  anticPkg::mode_t     modeReg;

  // Bit 6 means wait for vblank on a jump and LMS on a display mode
  logic optionBit;

  // Set by reset so that the very first instruction gets fetched
  logic firstFetch;

  logic [$clog2(anticPkg::VblankWaitCycles)-1:0] waitCount;

  assign line.mode = modeReg;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state      <= anticPkg::SeqIdle;
      modeReg    <= anticPkg::ModeBlank;
      optionBit  <= 1'b0;
      firstFetch <= 1'b1;
      waitCount  <= '0;
      loadIr     <= 1'b0;
      loadDlistL <= 1'b0;
      loadDlistH <= 1'b0;
      loadPtr    <= 1'b0;
      writeDlist <= 1'b0;
      loadDlist  <= 1'b0;
      dlistEnd   <= 1'b0;
      loadMsrL   <= 1'b0;
      loadMsrH   <= 1'b0;
      writeNmi   <= 1'b0;
      writeDli   <= 1'b0;
      clearDli   <= 1'b0;
      line.start <= 1'b0;
      line.width <= '0;
    end else begin
      // Strobes last a single cycle unless a state raises them again
      loadIr     <= 1'b0;
      loadDlistL <= 1'b0;
      loadDlistH <= 1'b0;
      writeDlist <= 1'b0;
      loadDlist  <= 1'b0;
      dlistEnd   <= 1'b0;
      loadMsrL   <= 1'b0;
      loadMsrH   <= 1'b0;
      line.start <= 1'b0;

      // The DLI sequence walks NMI, DLI write and DLI clear on successive cycles
      writeNmi <= 1'b0;
      writeDli <= writeNmi;
      clearDli <= writeDli;

      case (state)
        anticPkg::SeqIdle: begin
          if (firstFetch) begin
            loadIr     <= 1'b1;
            firstFetch <= 1'b0;
          end else if (irRdy) begin
            modeReg   <= ir[3:0];
            optionBit <= ir[6];
            writeNmi  <= ir[7];
            state     <= anticPkg::SeqDecode;
          end
        end

        anticPkg::SeqDecode: begin
          case (modeReg)
            anticPkg::ModeJump: begin
              loadIr <= 1'b1;
              state  <= anticPkg::SeqJumpLo;
            end
            anticPkg::ModeChar, anticPkg::ModeMapDouble, anticPkg::ModeMapSingle: begin
              if (optionBit) begin
                loadIr <= 1'b1;
                state  <= anticPkg::SeqLmsLo;
              end else begin
                line.start <= 1'b1;
                line.width <= playfieldWidth;
                state      <= anticPkg::SeqLine;
              end
            end
            default: begin
              // Blank and all modes not handled here fetch the next instruction
              loadIr <= 1'b1;
              state  <= anticPkg::SeqIdle;
            end
          endcase
        end

        anticPkg::SeqJumpLo: begin
          if (irRdy) begin
            loadDlistL <= 1'b1;
            loadPtr    <= 1'b1;
            loadIr     <= 1'b1;
            state      <= anticPkg::SeqJumpHi;
          end
        end

        anticPkg::SeqJumpHi: begin
          if (irRdy) begin
            loadDlistH <= 1'b1;
            writeDlist <= 1'b1;
            state      <= anticPkg::SeqJumpExec;
          end
        end

        anticPkg::SeqJumpExec: begin
          loadPtr   <= 1'b0;
          loadDlist <= 1'b1;
          dlistEnd  <= optionBit;
          state     <= anticPkg::SeqJumpEnd;
        end

        anticPkg::SeqJumpEnd: begin
          if (optionBit) begin
            waitCount <= '0;
            state     <= anticPkg::SeqVblankWait;
          end else begin
            loadIr <= 1'b1;
            state  <= anticPkg::SeqIdle;
          end
        end

        anticPkg::SeqVblankWait: begin
          if (waitCount == anticPkg::VblankWaitCycles - 1) begin
            loadIr <= 1'b1;
            state  <= anticPkg::SeqIdle;
          end else begin
            waitCount <= waitCount + 1'b1;
          end
        end

        anticPkg::SeqLmsLo: begin
          if (irRdy) begin
            loadMsrL <= 1'b1;
            loadIr   <= 1'b1;
            state    <= anticPkg::SeqLmsHi;
          end
        end

        anticPkg::SeqLmsHi: begin
          if (irRdy) begin
            loadMsrH <= 1'b1;
            state    <= anticPkg::SeqLmsEnd;
          end
        end

        anticPkg::SeqLmsEnd: begin
          line.start <= 1'b1;
          line.width <= playfieldWidth;
          state      <= anticPkg::SeqLine;
        end

        anticPkg::SeqLine: begin
          if (line.done) begin
            loadIr <= 1'b1;
            state  <= anticPkg::SeqIdle;
          end
        end

        default: state <= anticPkg::SeqIdle;
      endcase
    end
  end

endmodule

/* hw/modeLineEngine.sv */
/* Mode line engine
   Fetches the screen bytes of one line, drives the pixel generators and registers the codes */
`timescale 1ns/1ps

module modeLineEngine (
  input  logic                  Fphi0,
  input  logic                  rst,
  input  anticPkg::byte_t       msrData,
  input  logic                  msrDataRdy,
  input  anticPkg::charBitmap_t charData,
  input  logic                  charLoaded,
  output anticPkg::anCode_t     an,
  output logic                  loadMsrData,
  output logic                  incrMsr,
  output logic                  loadChar,
  lineCtrlIf.eng                line
);

  anticPkg::lineState_t state;
  anticPkg::mode_t      modeReg;
  anticPkg::byteCount_t bytesLeft;
  anticPkg::byteCount_t lineBytes;
  logic                 charWait;
  logic                 charMode;
  logic                 charStart;
  logic                 mapStart;
  anticPkg::anCode_t    charPixel;
  anticPkg::anCode_t    mapPixel;
  logic                 charValid;
  logic                 mapValid;
  logic                 charLast;
  logic                 mapLast;

  always_comb begin
    case (line.width)
      2'd1:    lineBytes = anticPkg::NarrowBytes;
      2'd2:    lineBytes = anticPkg::StandardBytes;
      2'd3:    lineBytes = anticPkg::WideBytes;
      default: lineBytes = '0;
    endcase
  end

  assign charMode  = (modeReg == anticPkg::ModeChar);
  // A text byte starts once its bitmap is in, a map byte as soon as it arrives
  assign charStart = (state == anticPkg::LineWaitData) && charWait && charLoaded;
  assign mapStart  = (state == anticPkg::LineWaitData) && !charMode && msrDataRdy;

  charPixelGen uCharGen (
    .Fphi0      (Fphi0),
    .rst        (rst),
    .load       (charStart),
    .bitmap     (charData),
    .pixel      (charPixel),
    .pixelValid (charValid),
    .last       (charLast)
  );

  mapPixelGen uMapGen (
    .Fphi0      (Fphi0),
    .rst        (rst),
    .load       (mapStart),
    .data       (msrData),
    .double     (modeReg == anticPkg::ModeMapDouble),
    .pixel      (mapPixel),
    .pixelValid (mapValid),
    .last       (mapLast)
  );

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      state       <= anticPkg::LineIdle;
      modeReg     <= anticPkg::ModeBlank;
      bytesLeft   <= '0;
      charWait    <= 1'b0;
      an          <= anticPkg::AnIdle;
      loadMsrData <= 1'b0;
      incrMsr     <= 1'b0;
      loadChar    <= 1'b0;
      line.done   <= 1'b0;
    end else begin
      loadMsrData <= 1'b0;
      incrMsr     <= 1'b0;
      loadChar    <= 1'b0;
      line.done   <= 1'b0;

      if (charMode) begin
        an <= charValid ? charPixel : anticPkg::AnIdle;
      end else begin
        an <= mapValid ? mapPixel : anticPkg::AnIdle;
      end

      case (state)
        anticPkg::LineIdle: begin
          if (line.start) begin
            modeReg <= line.mode;
            if (lineBytes == '0) begin
              line.done <= 1'b1;
            end else begin
              bytesLeft <= lineBytes;
              state     <= anticPkg::LineFetch;
            end
          end
        end

        anticPkg::LineFetch: begin
          if (bytesLeft == '0) begin
            line.done <= 1'b1;
            state     <= anticPkg::LineIdle;
          end else begin
            loadMsrData <= 1'b1;
            incrMsr     <= 1'b1;
            state       <= anticPkg::LineWaitData;
          end
        end

        anticPkg::LineWaitData: begin
          if (charWait) begin
            if (charLoaded) begin
              charWait <= 1'b0;
              state    <= anticPkg::LineEmit;
            end
          end else if (msrDataRdy) begin
            if (charMode) begin
              // The screen byte names a character, its bitmap comes next
              loadChar <= 1'b1;
              charWait <= 1'b1;
            end else begin
              state <= anticPkg::LineEmit;
            end
          end
        end

        anticPkg::LineEmit: begin
          if (charMode ? charLast : mapLast) begin
            bytesLeft <= bytesLeft - 1'b1;
            state     <= anticPkg::LineFetch;
          end
        end

        default: state <= anticPkg::LineIdle;
      endcase
    end
  end

endmodule

/* hw/mapPixelGen.sv */
/* Map pixel generator
   Splits a screen byte into four 2-bit pixels, high pair first, optionally showing each twice */
`timescale 1ns/1ps

module mapPixelGen (
  input  logic              Fphi0,
  input  logic              rst,
  input  logic              load,
  input  anticPkg::byte_t   data,
  input  logic              double,
  output anticPkg::anCode_t pixel,
  output logic              pixelValid,
  output logic              last
);

  anticPkg::byte_t shiftReg;
  logic            active;
  logic            doubled;
  logic            repeatPhase;
  logic [1:0]      pixIdx;
  logic            stepPixel;

  // A pixel moves on after one cycle, or after its second cycle when doubled
  assign stepPixel = !doubled || repeatPhase;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      active      <= 1'b0;
      doubled     <= 1'b0;
      repeatPhase <= 1'b0;
      pixIdx      <= '0;
    end else if (load) begin
      active      <= 1'b1;
      doubled     <= double;
      repeatPhase <= 1'b0;
      pixIdx      <= '0;
    end else if (active) begin
      if (stepPixel) begin
        repeatPhase <= 1'b0;
        pixIdx      <= pixIdx + 1'b1;
        if (pixIdx == 2'd3) begin
          active <= 1'b0;
        end
      end else begin
        repeatPhase <= 1'b1;
      end
    end
  end

  always_ff @(posedge Fphi0) begin
    if (load) begin
      shiftReg <= data;
    end else if (active && stepPixel) begin
      shiftReg <= shiftReg << 2;
    end
  end

  assign pixelValid = active;
  assign last       = active && (pixIdx == 2'd3) && stepPixel;

  always_comb begin
    case (shiftReg[7:6])
      2'd0:    pixel = anticPkg::AnBg;
      2'd1:    pixel = anticPkg::AnPf0;
      2'd2:    pixel = anticPkg::AnPf1;
      default: pixel = anticPkg::AnPf2;
    endcase
  end

endmodule

/* hw/charPixelGen.sv */
/* Character pixel generator
   Steps through a 64-bit character bitmap and emits text foreground or background codes */
`timescale 1ns/1ps

module charPixelGen (
  input  logic                  Fphi0,
  input  logic                  rst,
  input  logic                  load,
  input  anticPkg::charBitmap_t bitmap,
  output anticPkg::anCode_t     pixel,
  output logic                  pixelValid,
  output logic                  last
);

  anticPkg::charBitmap_t bits;
  logic                  active;
  logic [$clog2(anticPkg::CharBits)-1:0] bitIdx;

  always_ff @(posedge Fphi0 or posedge rst) begin
    if (rst) begin
      active <= 1'b0;
      bitIdx <= '0;
    end else if (load) begin
      active <= 1'b1;
      bitIdx <= '0;
    end else if (active) begin
      bitIdx <= bitIdx + 1'b1;
      if (last) begin
        active <= 1'b0;
      end
    end
  end

  // Bitmap held for the whole character
  always_ff @(posedge Fphi0) begin
    if (load) begin
      bits <= bitmap;
    end
  end

  assign pixelValid = active;
  assign last       = active && (bitIdx == anticPkg::CharBits - 1);

  // Set bits are text foreground, clear bits text background
  assign pixel = bits[bitIdx] ? anticPkg::AnPf1 : anticPkg::AnPf2;

endmodule

/* hw/lineCtrlIf.sv */
/* lineCtrlIf
   Start and done handshake for one mode line between the sequencer and the line engine */
`timescale 1ns/1ps

interface lineCtrlIf;

  // Start is a one-cycle pulse and mode and width are valid with it
  logic start;
  anticPkg::mode_t mode;
  anticPkg::pfWidth_t width;

  // One-cycle pulse once the last byte of the line is out
  logic done;

  modport seq (
    output start,
    output mode,
    output width,
    input  done
  );

  modport eng (
    input  start,
    input  mode,
    input  width,
    output done
  );

endinterface

/* hw/anticPkg.sv */
/* anticPkg
   Widths, pixel codes, mode numbers, line byte counts and FSM encodings of the translator */
package anticPkg;

  // Plain vectors that carry a meaning on the buses
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  anCode_t;
  typedef logic [3:0]  mode_t;
  typedef logic [1:0]  pfWidth_t;
  typedef logic [6:0]  byteCount_t;
  typedef logic [63:0] charBitmap_t;

  // Pixel codes sent to the colour chip
  localparam anCode_t AnIdle = 4'h8;
  localparam anCode_t AnBg   = 4'h0;
  localparam anCode_t AnPf0  = 4'h4;
  localparam anCode_t AnPf1  = 4'h5;
  localparam anCode_t AnPf2  = 4'h6;

  // Instruction mode field values that the translator handles
  localparam mode_t ModeBlank     = 4'd0;
  localparam mode_t ModeJump      = 4'd1;
  localparam mode_t ModeChar      = 4'd2;
  localparam mode_t ModeMapDouble = 4'd13;
  localparam mode_t ModeMapSingle = 4'd14;

  // Bytes per mode line for narrow, standard and wide playfields
  localparam byteCount_t NarrowBytes   = 7'd32;
  localparam byteCount_t StandardBytes = 7'd40;
  localparam byteCount_t WideBytes     = 7'd48;

  localparam int CharBits = 64;

  // Idle cycles spent after a jump that waits for vertical blank
  localparam int VblankWaitCycles = 5012;

  typedef enum logic [3:0] {
    SeqIdle,
    SeqDecode,
    SeqJumpLo,
    SeqJumpHi,
    SeqJumpExec,
    SeqJumpEnd,
    SeqVblankWait,
    SeqLmsLo,
    SeqLmsHi,
    SeqLmsEnd,
    SeqLine
  } seqState_t;

  typedef enum logic [1:0] {
    LineIdle,
    LineFetch,
    LineWaitData,
    LineEmit
  } lineState_t;

endpackage
